// File: Bender.yml
package:
  name: axi_mem

sources:
  - common/axi_mem_pkg.sv
  - common/burst_cmd_if.sv
  - common/mem_port_if.sv
  - src/write/wr_addr_phase.sv
  - src/write/wr_data_phase.sv
  - src/read/rd_addr_phase.sv
  - src/read/rd_data_phase.sv
  - src/mem_array.sv
  - src/axi_mem_top.sv
  - target: simulation
    files:
      - tb/tb_axi_mem.sv

// File: common/axi_mem_pkg.sv
`default_nettype none

package axi_mem_pkg;

   // AXI4 command field widths
   localparam int LEN_W  = 8;
   localparam int SIZE_W = 3;

   // burst type encoding (the fourth code is reserved and treated as illegal)
   typedef enum logic [1:0] {
      FIXED = 2'b00,
      INCR  = 2'b01,
      WRAP  = 2'b10
   } burst_e;

   // response encoding, only the two codes this slave returns
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } resp_e;

endpackage

`default_nettype wire

// File: common/burst_cmd_if.sv
`timescale 1ns/10ps
`default_nettype none

interface burst_cmd_if #(
   parameter int AXI_AW = 32,
   parameter int AXI_IW = 4
);

   logic                           valid;
   logic                           ready;
   logic [AXI_IW-1:0]              id;
   logic [AXI_AW-1:0]              addr;
   logic [axi_mem_pkg::LEN_W-1:0]  len;
   axi_mem_pkg::burst_e            burst;
   // burst is answered with SLVERR and touches no memory
   logic                           err;

   modport src (output valid, id, addr, len, burst, err, input ready);
   modport dst (input valid, id, addr, len, burst, err, output ready);

endinterface

`default_nettype wire

// File: common/mem_port_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mem_port_if #(
   parameter int AXI_DW    = 32,
   parameter int MEM_DEPTH = 1024
);

   localparam int IDX_W  = $clog2(MEM_DEPTH);
   localparam int STRB_W = AXI_DW / 8;

   logic              en;
   logic              we;
   logic [IDX_W-1:0]  idx;
   logic [AXI_DW-1:0] wdata;
   logic [STRB_W-1:0] strb;
   // valid the cycle after a read is issued
   logic [AXI_DW-1:0] rdata;

   modport master (output en, we, idx, wdata, strb, input rdata);
   modport slave (input en, we, idx, wdata, strb, output rdata);

endinterface

`default_nettype wire

// File: src.f
common/axi_mem_pkg.sv
common/burst_cmd_if.sv
common/mem_port_if.sv
src/write/wr_addr_phase.sv
src/write/wr_data_phase.sv
src/read/rd_addr_phase.sv
src/read/rd_data_phase.sv
src/mem_array.sv
src/axi_mem_top.sv
tb/tb_axi_mem.sv

// File: src/axi_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module axi_mem_top #(
   parameter int AXI_DW    = 32,
   parameter int AXI_AW    = 32,
   parameter int AXI_IW    = 4,
   parameter int MEM_DEPTH = 1024
) (
   input  logic                           axi_clk_i,
   input  logic                           rst_i,
   // write address
   input  logic [AXI_IW-1:0]              awid_i,
   input  logic [AXI_AW-1:0]              awaddr_i,
   input  logic [axi_mem_pkg::LEN_W-1:0]  awlen_i,
   input  logic [axi_mem_pkg::SIZE_W-1:0] awsize_i,
   input  logic [1:0]                     awburst_i,
   input  logic                           awvalid_i,
   output logic                           awready_o,
   // write data and response
   input  logic [AXI_DW-1:0]              wdata_i,
   input  logic [AXI_DW/8-1:0]            wstrb_i,
   input  logic                           wlast_i,
   input  logic                           wvalid_i,
   output logic                           wready_o,
   output logic [AXI_IW-1:0]              bid_o,
   output logic [1:0]                     bresp_o,
   output logic                           bvalid_o,
   input  logic                           bready_i,
   // read address
   input  logic [AXI_IW-1:0]              arid_i,
   input  logic [AXI_AW-1:0]              araddr_i,
   input  logic [axi_mem_pkg::LEN_W-1:0]  arlen_i,
   input  logic [axi_mem_pkg::SIZE_W-1:0] arsize_i,
   input  logic [1:0]                     arburst_i,
   input  logic                           arvalid_i,
   output logic                           arready_o,
   // read data
   output logic [AXI_IW-1:0]              rid_o,
   output logic [AXI_DW-1:0]              rdata_o,
   output logic [1:0]                     rresp_o,
   output logic                           rlast_o,
   output logic                           rvalid_o,
   input  logic                           rready_i
);

   burst_cmd_if #(.AXI_AW(AXI_AW), .AXI_IW(AXI_IW)) aw_cmd ();
   burst_cmd_if #(.AXI_AW(AXI_AW), .AXI_IW(AXI_IW)) ar_cmd ();

   // word index is byte address / strobe width, mod MEM_DEPTH, formed in the data phases
   mem_port_if #(.AXI_DW(AXI_DW), .MEM_DEPTH(MEM_DEPTH)) wr_port ();
   mem_port_if #(.AXI_DW(AXI_DW), .MEM_DEPTH(MEM_DEPTH)) rd_port ();

   wr_addr_phase #(.AXI_DW(AXI_DW), .AXI_AW(AXI_AW), .AXI_IW(AXI_IW)) aw_i (
      .axi_clk_i (axi_clk_i),
      .rst_i     (rst_i),
      .awid_i    (awid_i),
      .awaddr_i  (awaddr_i),
      .awlen_i   (awlen_i),
      .awsize_i  (awsize_i),
      .awburst_i (awburst_i),
      .awvalid_i (awvalid_i),
      .awready_o (awready_o),
      .cmd_o     (aw_cmd.src)
   );

   wr_data_phase #(
      .AXI_DW    (AXI_DW),
      .AXI_AW    (AXI_AW),
      .AXI_IW    (AXI_IW),
      .MEM_DEPTH (MEM_DEPTH)
   ) w_i (
      .axi_clk_i (axi_clk_i),
      .rst_i     (rst_i),
      .wdata_i   (wdata_i),
      .wstrb_i   (wstrb_i),
      .wlast_i   (wlast_i),
      .wvalid_i  (wvalid_i),
      .wready_o  (wready_o),
      .bid_o     (bid_o),
      .bresp_o   (bresp_o),
      .bvalid_o  (bvalid_o),
      .bready_i  (bready_i),
      .cmd_i     (aw_cmd.dst),
      .mem_o     (wr_port.master)
   );

   rd_addr_phase #(.AXI_DW(AXI_DW), .AXI_AW(AXI_AW), .AXI_IW(AXI_IW)) ar_i (
      .axi_clk_i (axi_clk_i),
      .rst_i     (rst_i),
      .arid_i    (arid_i),
      .araddr_i  (araddr_i),
      .arlen_i   (arlen_i),
      .arsize_i  (arsize_i),
      .arburst_i (arburst_i),
      .arvalid_i (arvalid_i),
      .arready_o (arready_o),
      .cmd_o     (ar_cmd.src)
   );

   rd_data_phase #(
      .AXI_DW    (AXI_DW),
      .AXI_AW    (AXI_AW),
      .AXI_IW    (AXI_IW),
      .MEM_DEPTH (MEM_DEPTH)
   ) r_i (
      .axi_clk_i (axi_clk_i),
      .rst_i     (rst_i),
      .rready_i  (rready_i),
      .rid_o     (rid_o),
      .rdata_o   (rdata_o),
      .rresp_o   (rresp_o),
      .rlast_o   (rlast_o),
      .rvalid_o  (rvalid_o),
      .cmd_i     (ar_cmd.dst),
      .mem_o     (rd_port.master)
   );

   mem_array #(.AXI_DW(AXI_DW), .MEM_DEPTH(MEM_DEPTH)) mem_i (
      .axi_clk_i (axi_clk_i),
      .wr_i      (wr_port.slave),
      .rd_i      (rd_port.slave)
   );

endmodule

`default_nettype wire

// File: src/mem_array.sv
`timescale 1ns/10ps
`default_nettype none

module mem_array #(
   parameter int AXI_DW    = 32,
   parameter int MEM_DEPTH = 1024
) (
   input  logic        axi_clk_i,
   mem_port_if.slave   wr_i,
   mem_port_if.slave   rd_i
);

   localparam int STRB_W = AXI_DW / 8;

   logic [AXI_DW-1:0] mem [MEM_DEPTH];
   logic [AXI_DW-1:0] wr_rdata_q;
   logic [AXI_DW-1:0] rd_rdata_q;

   // replace only the strobed bytes of a stored word
   function automatic logic [AXI_DW-1:0] merge_bytes(
      input logic [AXI_DW-1:0] old_word,
      input logic [AXI_DW-1:0] new_word,
      input logic [STRB_W-1:0] strb
   );
      logic [AXI_DW-1:0] res;
      res = old_word;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return res;
   endfunction

   // both ports see the old word on a same-cycle collision
   always_ff @(posedge axi_clk_i) begin
      if (wr_i.en) begin
         if (wr_i.we) begin
            mem[wr_i.idx] <= merge_bytes(mem[wr_i.idx], wr_i.wdata, wr_i.strb);
         end else begin
            wr_rdata_q <= mem[wr_i.idx];
         end
      end
      if (rd_i.en) begin
         if (rd_i.we) begin
            mem[rd_i.idx] <= merge_bytes(mem[rd_i.idx], rd_i.wdata, rd_i.strb);
         end else begin
            rd_rdata_q <= mem[rd_i.idx];
         end
      end
   end

   assign wr_i.rdata = wr_rdata_q;
   assign rd_i.rdata = rd_rdata_q;

endmodule

`default_nettype wire

// File: src/read/rd_addr_phase.sv
`timescale 1ns/10ps
`default_nettype none

module rd_addr_phase #(
   parameter int AXI_DW = 32,
   parameter int AXI_AW = 32,
   parameter int AXI_IW = 4
) (
   input  logic                               axi_clk_i,
   input  logic                               rst_i,
   input  logic [AXI_IW-1:0]                  arid_i,
   input  logic [AXI_AW-1:0]                  araddr_i,
   input  logic [axi_mem_pkg::LEN_W-1:0]      arlen_i,
   input  logic [axi_mem_pkg::SIZE_W-1:0]     arsize_i,
   input  logic [1:0]                         arburst_i,
   input  logic                               arvalid_i,
   output logic                               arready_o,
   burst_cmd_if.src                           cmd_o
);

   localparam int SIZE_FULL = $clog2(AXI_DW / 8);

   logic arready_q;
   logic bad_burst;
   logic bad_size;

   // WRAP, reserved and narrow bursts get SLVERR
   assign bad_burst = (arburst_i != axi_mem_pkg::FIXED) && (arburst_i != axi_mem_pkg::INCR);
   assign bad_size  = arsize_i != SIZE_FULL[axi_mem_pkg::SIZE_W-1:0];

   always_ff @(posedge axi_clk_i) begin
      if (rst_i) begin
         arready_q   <= 1'b0;
         cmd_o.valid <= 1'b0;
      end else if (arvalid_i && arready_q) begin
         arready_q   <= 1'b0;
         cmd_o.valid <= 1'b1;
      end else if (cmd_o.valid && cmd_o.ready) begin
         arready_q   <= 1'b1;
         cmd_o.valid <= 1'b0;
      end else if (!cmd_o.valid) begin
         arready_q <= 1'b1;
      end
   end

   always_ff @(posedge axi_clk_i) begin
      if (arvalid_i && arready_q) begin
         cmd_o.id    <= arid_i;
         cmd_o.addr  <= araddr_i;
         cmd_o.len   <= arlen_i;
         cmd_o.burst <= axi_mem_pkg::burst_e'(arburst_i);
         cmd_o.err   <= bad_burst || bad_size;
      end
   end

   assign arready_o = arready_q;

endmodule

`default_nettype wire

// File: src/read/rd_data_phase.sv
`timescale 1ns/10ps
`default_nettype none

module rd_data_phase #(
   parameter int AXI_DW    = 32,
   parameter int AXI_AW    = 32,
   parameter int AXI_IW    = 4,
   parameter int MEM_DEPTH = 1024
) (
   input  logic                  axi_clk_i,
   input  logic                  rst_i,
   input  logic                  rready_i,
   output logic [AXI_IW-1:0]     rid_o,
   output logic [AXI_DW-1:0]     rdata_o,
   output logic [1:0]            rresp_o,
   output logic                  rlast_o,
   output logic                  rvalid_o,
   burst_cmd_if.dst              cmd_i,
   mem_port_if.master            mem_o
);

   localparam int OFFS_W = $clog2(AXI_DW / 8);
   localparam int IDX_W  = $clog2(MEM_DEPTH);

   logic                          cmd_ready_q;
   logic                          run_q;
   logic                          rvalid_q;
   logic                          rlast_q;
   logic [axi_mem_pkg::LEN_W-1:0] cnt_q;
   logic                          cmd_take;
   logic                          issue;
   logic [AXI_AW-1:0]             word_addr;
   logic [AXI_IW-1:0]             id_q;
   logic [axi_mem_pkg::LEN_W-1:0] len_q;
   axi_mem_pkg::burst_e           burst_q;
   logic                          err_q;
   logic [IDX_W-1:0]              idx_q;

   assign cmd_take  = cmd_i.valid && cmd_ready_q;
   assign word_addr = cmd_i.addr >> OFFS_W;
   // next read goes out when the held beat is empty or leaving
   assign issue     = run_q && (!rvalid_q || rready_i);

   always_ff @(posedge axi_clk_i) begin
      if (rst_i) begin
         cmd_ready_q <= 1'b0;
         run_q       <= 1'b0;
         rvalid_q    <= 1'b0;
         rlast_q     <= 1'b0;
         cnt_q       <= '0;
      end else if (cmd_take) begin
         cmd_ready_q <= 1'b0;
         run_q       <= 1'b1;
         cnt_q       <= '0;
      end else if (issue) begin
         rvalid_q <= 1'b1;
         rlast_q  <= (cnt_q == len_q);
         cnt_q    <= cnt_q + 1'b1;
         if (cnt_q == len_q) begin
            run_q <= 1'b0;
         end
      end else if (rvalid_q && rready_i) begin
         // nothing left to issue, so this was the rlast beat
         rvalid_q    <= 1'b0;
         cmd_ready_q <= 1'b1;
      end else if (!run_q && !rvalid_q) begin
         cmd_ready_q <= 1'b1;
      end
   end

   always_ff @(posedge axi_clk_i) begin
      if (cmd_take) begin
         id_q    <= cmd_i.id;
         len_q   <= cmd_i.len;
         burst_q <= cmd_i.burst;
         err_q   <= cmd_i.err;
         idx_q   <= IDX_W'(word_addr % MEM_DEPTH);
      end else if (issue && (burst_q == axi_mem_pkg::INCR)) begin
         idx_q <= (idx_q == IDX_W'(MEM_DEPTH - 1)) ? '0 : idx_q + 1'b1;
      end
   end

   assign mem_o.en    = issue && !err_q;
   assign mem_o.we    = 1'b0;
   assign mem_o.idx   = idx_q;
   assign mem_o.wdata = '0;
   assign mem_o.strb  = '0;

   // array output register holds the beat until rready
   assign rdata_o     = err_q ? '0 : mem_o.rdata;
   assign rresp_o     = err_q ? axi_mem_pkg::SLVERR : axi_mem_pkg::OKAY;
   assign rid_o       = id_q;
   assign rlast_o     = rlast_q;
   assign rvalid_o    = rvalid_q;
   assign cmd_i.ready = cmd_ready_q;

endmodule

`default_nettype wire

// File: src/write/wr_addr_phase.sv
`timescale 1ns/10ps
`default_nettype none

module wr_addr_phase #(
   parameter int AXI_DW = 32,
   parameter int AXI_AW = 32,
   parameter int AXI_IW = 4
) (
   input  logic                               axi_clk_i,
   input  logic                               rst_i,
   input  logic [AXI_IW-1:0]                  awid_i,
   input  logic [AXI_AW-1:0]                  awaddr_i,
   input  logic [axi_mem_pkg::LEN_W-1:0]      awlen_i,
   input  logic [axi_mem_pkg::SIZE_W-1:0]     awsize_i,
   input  logic [1:0]                         awburst_i,
   input  logic                               awvalid_i,
   output logic                               awready_o,
   burst_cmd_if.src                           cmd_o
);

   localparam int SIZE_FULL = $clog2(AXI_DW / 8);

   logic awready_q;
   logic bad_burst;
   logic bad_size;

   // only full width FIXED and INCR bursts are served
   assign bad_burst = (awburst_i != axi_mem_pkg::FIXED) && (awburst_i != axi_mem_pkg::INCR);
   assign bad_size  = awsize_i != SIZE_FULL[axi_mem_pkg::SIZE_W-1:0];

   always_ff @(posedge axi_clk_i) begin
      if (rst_i) begin
         awready_q   <= 1'b0;
         cmd_o.valid <= 1'b0;
      end else if (awvalid_i && awready_q) begin
         awready_q   <= 1'b0;
         cmd_o.valid <= 1'b1;
      end else if (cmd_o.valid && cmd_o.ready) begin
         awready_q   <= 1'b1;
         cmd_o.valid <= 1'b0;
      end else if (!cmd_o.valid) begin
         awready_q <= 1'b1;
      end
   end

   always_ff @(posedge axi_clk_i) begin
      if (awvalid_i && awready_q) begin
         cmd_o.id    <= awid_i;
         cmd_o.addr  <= awaddr_i;
         cmd_o.len   <= awlen_i;
         cmd_o.burst <= axi_mem_pkg::burst_e'(awburst_i);
         cmd_o.err   <= bad_burst || bad_size;
      end
   end

   assign awready_o = awready_q;

endmodule

`default_nettype wire

// File: src/write/wr_data_phase.sv
`timescale 1ns/10ps
`default_nettype none

module wr_data_phase #(
   parameter int AXI_DW    = 32,
   parameter int AXI_AW    = 32,
   parameter int AXI_IW    = 4,
   parameter int MEM_DEPTH = 1024
) (
   input  logic                  axi_clk_i,
   input  logic                  rst_i,
   input  logic [AXI_DW-1:0]     wdata_i,
   input  logic [AXI_DW/8-1:0]   wstrb_i,
   input  logic                  wlast_i,
   input  logic                  wvalid_i,
   output logic                  wready_o,
   output logic [AXI_IW-1:0]     bid_o,
   output logic [1:0]            bresp_o,
   output logic                  bvalid_o,
   input  logic                  bready_i,
   burst_cmd_if.dst              cmd_i,
   mem_port_if.master            mem_o
);

   localparam int OFFS_W = $clog2(AXI_DW / 8);
   localparam int IDX_W  = $clog2(MEM_DEPTH);

   logic                cmd_ready_q;
   logic                wready_q;
   logic                bvalid_q;
   logic                cmd_take;
   logic                beat;
   logic [AXI_AW-1:0]   word_addr;
   logic [AXI_IW-1:0]   id_q;
   axi_mem_pkg::burst_e burst_q;
   logic                err_q;
   logic [IDX_W-1:0]    idx_q;

   assign cmd_take  = cmd_i.valid && cmd_ready_q;
   assign beat      = wvalid_i && wready_q;
   assign word_addr = cmd_i.addr >> OFFS_W;

   // idle -> data beats -> response, one burst at a time
   always_ff @(posedge axi_clk_i) begin
      if (rst_i) begin
         cmd_ready_q <= 1'b0;
         wready_q    <= 1'b0;
         bvalid_q    <= 1'b0;
      end else if (cmd_take) begin
         cmd_ready_q <= 1'b0;
         wready_q    <= 1'b1;
      end else if (beat && wlast_i) begin
         wready_q <= 1'b0;
         bvalid_q <= 1'b1;
      end else if (bvalid_q && bready_i) begin
         bvalid_q    <= 1'b0;
         cmd_ready_q <= 1'b1;
      end else if (!wready_q && !bvalid_q) begin
         cmd_ready_q <= 1'b1;
      end
   end

   always_ff @(posedge axi_clk_i) begin
      if (cmd_take) begin
         id_q    <= cmd_i.id;
         burst_q <= cmd_i.burst;
         err_q   <= cmd_i.err;
         idx_q   <= IDX_W'(word_addr % MEM_DEPTH);
      end else if (beat && (burst_q == axi_mem_pkg::INCR)) begin
         // step one word, wrapping at the end of the array
         idx_q <= (idx_q == IDX_W'(MEM_DEPTH - 1)) ? '0 : idx_q + 1'b1;
      end
   end

   // each accepted beat writes at the same edge
   assign mem_o.en    = beat && !err_q;
   assign mem_o.we    = 1'b1;
   assign mem_o.idx   = idx_q;
   assign mem_o.wdata = wdata_i;
   assign mem_o.strb  = wstrb_i;

   assign cmd_i.ready = cmd_ready_q;
   assign wready_o    = wready_q;
   assign bvalid_o    = bvalid_q;
   assign bid_o       = id_q;
   assign bresp_o     = err_q ? axi_mem_pkg::SLVERR : axi_mem_pkg::OKAY;

endmodule

`default_nettype wire

// File: tb/tb_axi_mem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axi_mem;

   localparam int DW        = 32;
   localparam int AW        = 32;
   localparam int IW        = 4;
   localparam int DEPTH     = 1024;
   localparam int SB        = DW / 8;
   localparam int RW        = IW + 3 + DW;
   localparam int MAX_WAIT  = 5000;
   localparam logic [2:0]  FULL_SIZE = 3'($clog2(SB));
   localparam logic [31:0] SEED      = 32'hd758_e08b;

   logic          axi_clk_i;
   logic          rst_i;
   logic [IW-1:0] awid_i;
   logic [AW-1:0] awaddr_i;
   logic [7:0]    awlen_i;
   logic [2:0]    awsize_i;
   logic [1:0]    awburst_i;
   logic          awvalid_i;
   logic          awready_o;
   logic [DW-1:0] wdata_i;
   logic [SB-1:0] wstrb_i;
   logic          wlast_i;
   logic          wvalid_i;
   logic          wready_o;
   logic [IW-1:0] bid_o;
   logic [1:0]    bresp_o;
   logic          bvalid_o;
   logic          bready_i;
   logic [IW-1:0] arid_i;
   logic [AW-1:0] araddr_i;
   logic [7:0]    arlen_i;
   logic [2:0]    arsize_i;
   logic [1:0]    arburst_i;
   logic          arvalid_i;
   logic          arready_o;
   logic [IW-1:0] rid_o;
   logic [DW-1:0] rdata_o;
   logic [1:0]    rresp_o;
   logic          rlast_o;
   logic          rvalid_o;
   logic          rready_i;

   logic [7:0]    model_mem [DEPTH*SB];
   // {id, resp, last, data} per expected R beat, {id, resp} per expected B
   logic [RW-1:0] r_exp [$];
   logic [IW+1:0] b_exp [$];
   logic [31:0]   main_lfsr;
   logic [31:0]   stall_lfsr;
   logic          stall_en;

   axi_mem_top #(.AXI_DW(DW), .AXI_AW(AW), .AXI_IW(IW), .MEM_DEPTH(DEPTH)) axi_mem_top_i (.*);

   initial begin
      axi_clk_i = 1'b0;
      forever #4 axi_clk_i = ~axi_clk_i;
   end

   // galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         state = lfsr_next(state);
         v = {v[30:0], state[0]};
      end
   endtask

   function automatic bit burst_ok(input logic [1:0] burst, input logic [2:0] size);
      return (burst == 2'b00 || burst == 2'b01) && (size == FULL_SIZE);
   endfunction

   // word hit by beat n, modulo the depth
   function automatic int beat_word(input logic [AW-1:0] addr, input logic [1:0] burst,
                                    input int n);
      return ((addr / SB) + ((burst == 2'b01) ? n : 0)) % DEPTH;
   endfunction

   function automatic void model_write(input int word, input logic [DW-1:0] data,
                                       input logic [SB-1:0] strb);
      for (int b = 0; b < SB; b++) begin
         if (strb[b]) begin
            model_mem[word*SB + b] = data[8*b +: 8];
         end
      end
   endfunction

   function automatic logic [DW-1:0] model_read(input int word);
      logic [DW-1:0] w;
      for (int b = 0; b < SB; b++) begin
         w[8*b +: 8] = model_mem[word*SB + b];
      end
      return w;
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1, "stopped at %0t", $time);
   endtask

   task automatic mismatch(input string name, input logic [DW-1:0] got,
                           input logic [DW-1:0] exp);
      fail_run($sformatf("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, got));
   endtask

   // ch 0 is AW, 1 is W, 2 is AR
   task automatic wait_handshake(input int ch, input string what);
      int n;
      n = 0;
      @(negedge axi_clk_i);
      while (!((ch == 0) ? awready_o : (ch == 1) ? wready_o : arready_o)) begin
         n++;
         if (n > MAX_WAIT) begin
            fail_run({"timeout waiting for ", what});
         end
         @(negedge axi_clk_i);
      end
   endtask

   task automatic wait_drain(input bit rd, input string what);
      int n;
      n = 0;
      while (rd ? (r_exp.size() != 0) : (b_exp.size() != 0)) begin
         n++;
         if (n > MAX_WAIT) begin
            fail_run({"timeout waiting for ", what});
         end
         @(negedge axi_clk_i);
      end
   endtask

   task automatic write_burst(input logic [IW-1:0] id, input logic [AW-1:0] addr,
                              input logic [7:0] len, input logic [2:0] size,
                              input logic [1:0] burst, input bit full_strb);
      logic [31:0] data;
      logic [31:0] strb;
      bit          ok;
      ok = burst_ok(burst, size);
      b_exp.push_back({id, ok ? 2'b00 : 2'b10});
      @(posedge axi_clk_i);
      #1;
      awid_i    = id;
      awaddr_i  = addr;
      awlen_i   = len;
      awsize_i  = size;
      awburst_i = burst;
      awvalid_i = 1'b1;
      wait_handshake(0, "awready");
      @(posedge axi_clk_i);
      #1;
      awvalid_i = 1'b0;
      for (int n = 0; n <= len; n++) begin
         take_bits(main_lfsr, DW, data);
         take_bits(main_lfsr, SB, strb);
         wdata_i  = data;
         wstrb_i  = full_strb ? '1 : strb[SB-1:0];
         wlast_i  = (n == len);
         wvalid_i = 1'b1;
         wait_handshake(1, "wready");
         if (ok) begin
            model_write(beat_word(addr, burst, n), wdata_i, wstrb_i);
         end
         @(posedge axi_clk_i);
         #1;
      end
      wvalid_i = 1'b0;
      wlast_i  = 1'b0;
      wait_drain(1'b0, "write response");
   endtask

   task automatic read_burst(input logic [IW-1:0] id, input logic [AW-1:0] addr,
                             input logic [7:0] len, input logic [2:0] size,
                             input logic [1:0] burst);
      bit ok;
      ok = burst_ok(burst, size);
      for (int n = 0; n <= len; n++) begin
         r_exp.push_back({id, ok ? 2'b00 : 2'b10, n == len,
                          ok ? model_read(beat_word(addr, burst, n)) : {DW{1'b0}}});
      end
      @(posedge axi_clk_i);
      #1;
      arid_i    = id;
      araddr_i  = addr;
      arlen_i   = len;
      arsize_i  = size;
      arburst_i = burst;
      arvalid_i = 1'b1;
      wait_handshake(2, "arready");
      @(posedge axi_clk_i);
      #1;
      arvalid_i = 1'b0;
      wait_drain(1'b1, "read data");
   endtask

   // every R and B transfer against the next expected one
   always @(negedge axi_clk_i) begin : compare
      logic [RW-1:0] r;
      logic [IW+1:0] b;
      if (!rst_i && rvalid_o && rready_i) begin
         if (r_exp.size() == 0) begin
            fail_run("R beat arrived while no read beat was outstanding");
         end else begin
            r = r_exp.pop_front();
            assert (rid_o == r[RW-1 -: IW]) else mismatch("rid", rid_o, r[RW-1 -: IW]);
            assert (rresp_o == r[DW+2:DW+1]) else mismatch("rresp", rresp_o, r[DW+2:DW+1]);
            assert (rlast_o == r[DW]) else mismatch("rlast", rlast_o, r[DW]);
            assert (rdata_o == r[DW-1:0]) else mismatch("rdata", rdata_o, r[DW-1:0]);
         end
      end
      if (!rst_i && bvalid_o && bready_i) begin
         if (b_exp.size() == 0) begin
            fail_run("B response arrived while no write burst was outstanding");
         end else begin
            b = b_exp.pop_front();
            assert (bid_o == b[IW+1:2]) else mismatch("bid", bid_o, b[IW+1:2]);
            assert (bresp_o == b[1:0]) else mismatch("bresp", bresp_o, b[1:0]);
         end
      end
   end

   // ready stalls about one cycle in four when enabled
   initial begin : stall_drive
      logic [31:0] v;
      stall_lfsr = SEED;
      forever begin
         @(posedge axi_clk_i);
         #1;
         take_bits(stall_lfsr, 2, v);
         rready_i = !stall_en || (v[1:0] != 2'b00);
         take_bits(stall_lfsr, 2, v);
         bready_i = !stall_en || (v[1:0] != 2'b00);
      end
   end

   initial begin : main
      logic [31:0] v;
      logic [31:0] w_idx;
      logic [31:0] r_idx;
      logic [31:0] w_len;
      logic [31:0] r_len;
      rst_i     = 1'b1;
      awid_i    = '0;
      awaddr_i  = '0;
      awlen_i   = '0;
      awsize_i  = '0;
      awburst_i = '0;
      awvalid_i = 1'b0;
      wdata_i   = '0;
      wstrb_i   = '0;
      wlast_i   = 1'b0;
      wvalid_i  = 1'b0;
      bready_i  = 1'b0;
      arid_i    = '0;
      araddr_i  = '0;
      arlen_i   = '0;
      arsize_i  = '0;
      arburst_i = '0;
      arvalid_i = 1'b0;
      rready_i  = 1'b0;
      stall_en  = 1'b0;
      main_lfsr = SEED;
      repeat (3) @(posedge axi_clk_i);
      #1;
      rst_i = 1'b0;
      repeat (4) @(negedge axi_clk_i);
      assert (!bvalid_o && !rvalid_o) else fail_run("bvalid or rvalid high after reset");

      // the array is not reset, so give every word a known value first
      for (int k = 0; k < DEPTH / 256; k++) begin
         write_burst(IW'(k), AW'(k * 256 * SB), 8'd255, FULL_SIZE, 2'b01, 1'b1);
      end
      repeat (8) begin
         take_bits(main_lfsr, 10, w_idx);
         take_bits(main_lfsr, 5, w_len);
         take_bits(main_lfsr, IW, v);
         write_burst(v[IW-1:0], w_idx * SB, w_len[7:0], FULL_SIZE, 2'b01, 1'b0);
         read_burst(v[IW-1:0], w_idx * SB, w_len[7:0], FULL_SIZE, 2'b01);
      end

      write_burst(4'd3, 32'h40, 8'd7, FULL_SIZE, 2'b00, 1'b0);
      read_burst(4'd3, 32'h40, 8'd0, FULL_SIZE, 2'b01);

      write_burst(4'd5, 32'h100, 8'd3, FULL_SIZE, 2'b10, 1'b0);
      write_burst(4'd6, 32'h100, 8'd3, 3'd1, 2'b01, 1'b0);
      read_burst(4'd7, 32'h100, 8'd3, FULL_SIZE, 2'b01);
      read_burst(4'd8, 32'h100, 8'd3, FULL_SIZE, 2'b10);
      read_burst(4'd9, 32'h100, 8'd5, 3'd0, 2'b01);

      // writes stay below word 300, reads above word 511
      stall_en = 1'b1;
      repeat (6) begin
         take_bits(main_lfsr, 8, w_idx);
         take_bits(main_lfsr, 5, w_len);
         take_bits(main_lfsr, 8, r_idx);
         take_bits(main_lfsr, 6, r_len);
         fork
            write_burst(4'd1, w_idx * SB, w_len[7:0], FULL_SIZE, 2'b01, 1'b0);
            read_burst(4'd2, (512 + r_idx) * SB, r_len[7:0], FULL_SIZE, 2'b01);
         join
         read_burst(4'd4, w_idx * SB, w_len[7:0], FULL_SIZE, 2'b01);
      end

      write_burst(4'd10, (DEPTH + 20) * SB, 8'd2, FULL_SIZE, 2'b01, 1'b0);
      read_burst(4'd11, 20 * SB, 8'd2, FULL_SIZE, 2'b01);
      read_burst(4'd12, (3 * DEPTH + 20) * SB, 8'd2, FULL_SIZE, 2'b01);

      repeat (4) @(posedge axi_clk_i);
      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire
